// File: Bender.yml
package:
  name: snappy_decompressor

sources:
  - src/snappy_pkg.sv
  - src/byte_fifo.sv
  - src/token_control.sv
  - src/history_ram.sv
  - src/output_packer.sv
  - src/snappy_decompressor.sv
  - target: test
    files:
      - sim/tb_snappy_decompressor.sv

// File: sim/tb_snappy_decompressor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snappy_decompressor;

	logic clk = 1'b0;
	logic rst_n;
	logic [7:0] data_i = 8'h00;
	logic valid_i = 1'b0;
	logic start_i;
	logic [snappy_pkg::LEN_W-1:0] decomp_len_i;
	logic wr_ready_i = 1'b1;
	logic fifo_almost_full_o;
	logic [snappy_pkg::WORD_W-1:0] data_o;
	logic [snappy_pkg::BYTES_PER_WORD-1:0] byte_valid_o;
	logic valid_o;
	logic last_o;
	logic done_o;

	int seed = 32'h9355_1135;
	logic [7:0] model [4096];                   // expected bytes of the current block
	int blk_len = 0;
	int comp_len = 0;
	logic [7:0] comp_q [$];                     // compressed bytes not yet taken
	logic [72:0] exp_q [$];                     // {last, mask, data} per word
	logic [63:0] exp_data;
	logic [63:0] exp_keep;
	logic [7:0] exp_mask;
	logic exp_last;
	logic exp_pending = 1'b0;
	logic af_seen = 1'b0;
	string test_name = "reset";
	int ready_low_pct = 0;
	int gap_pct = 0;
	int limit = 200;                            // grows with every block
	int cycles = 0;
	int done_cnt = 0;
	int assert_errs = 0;
	int check_errs = 0;
	int passes = 0;
	int fails = 0;

	snappy_decompressor snappy_decompressor_i (.*);

	always #2 clk = ~clk;

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic put_byte(input logic [7:0] b);
		comp_q.push_back(b);
		comp_len++;
	endtask

	task automatic copy_model(input int off, input int len);
		for (int i = 0; i < len; i++) begin
			model[blk_len] = model[blk_len - off];  // byte by byte so that an overlap repeats
			blk_len++;
		end
	endtask

	task automatic add_literal(input int len);
		snappy_pkg::tag_u t;
		t.lit.len_m1 = 6'(len - 1);
		t.lit.kind = snappy_pkg::TAG_LITERAL;
		put_byte(t);
		for (int i = 0; i < len; i++) begin
			model[blk_len] = 8'($random(seed));
			put_byte(model[blk_len]);
			blk_len++;
		end
	endtask

	task automatic add_copy1(input int off, input int len);
		snappy_pkg::tag_u t;
		t.cp1.off_hi = 3'(off >> 8);
		t.cp1.len_m4 = 3'(len - 4);
		t.cp1.kind = snappy_pkg::TAG_COPY_1;
		put_byte(t);
		put_byte(8'(off));
		copy_model(off, len);
	endtask

	task automatic add_copy2(input int off, input int len);
		snappy_pkg::tag_u t;
		t.lit.len_m1 = 6'(len - 1);
		t.lit.kind = snappy_pkg::TAG_COPY_2;
		put_byte(t);
		put_byte(8'(off));
		put_byte(8'(off >> 8));
		copy_model(off, len);
	endtask

	// offsets never reach past the bytes already produced
	task automatic fill_random(input int target, input bit with_copy1);
		int kind;
		int span;
		while (blk_len < target) begin
			kind = rand_below(4);
			span = (blk_len < 2047) ? blk_len : 2047;
			if (blk_len == 0 || kind == 0) add_literal(1 + rand_below(60));
			else if (kind == 1 && with_copy1) add_copy1(1 + rand_below(span), 4 + rand_below(8));
			else add_copy2(1 + rand_below(span), 1 + rand_below(64));
		end
	endtask

	task automatic queue_words();
		int n;
		logic [63:0] d;
		logic [7:0] m;
		n = (blk_len + 7) / 8;
		for (int w = 0; w < n; w++) begin
			d = '0;
			m = '0;
			for (int b = 0; b < 8 && w * 8 + b < blk_len; b++) begin
				d[b*8 +: 8] = model[w * 8 + b];
				m[b] = 1'b1;
			end
			exp_q.push_back({(w == n - 1), m, d});
		end
	endtask

	task automatic run_block(input string name, input int ready_low, input int gap);
		int dones_before;
		int errs_before;
		test_name = name;
		ready_low_pct = ready_low;
		gap_pct = gap;
		limit += 4 * (comp_len + blk_len);
		queue_words();
		errs_before = assert_errs + check_errs;
		dones_before = done_cnt;
		start_i = 1'b1;
		decomp_len_i = snappy_pkg::LEN_W'(blk_len);
		@(negedge clk);
		start_i = 1'b0;
		while (done_cnt == dones_before) @(negedge clk);
		repeat (20) @(negedge clk);                // quiet tail where no stray word may appear
		assert (done_cnt == dones_before + 1) else begin
			$display("ERR %s: done pulses expected 1 actual %0d", name, done_cnt - dones_before);
			check_errs++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%s: %0d output words never arrived", name, exp_q.size());
			check_errs++;
		end
		if (assert_errs + check_errs == errs_before) begin
			passes++;
			$display("%s: ok, %0d bytes", name, blk_len);
		end else begin
			fails++;
			$display("%s: FAILED", name);
		end
		blk_len = 0;
		comp_len = 0;
	endtask

	// a compressed byte stays on data_i until the DUT takes it
	always @(negedge clk) begin
		if (valid_i && !af_seen) void'(comp_q.pop_front());
		af_seen = fifo_almost_full_o;             // level at the coming rising edge
		valid_i = (comp_q.size() > 0) && (rand_below(100) >= gap_pct);
		data_i = (comp_q.size() > 0) ? comp_q[0] : 8'h00;
		wr_ready_i = (rand_below(100) >= ready_low_pct);
	end

	always @(posedge clk) begin
		logic [72:0] head;
		if (valid_o && wr_ready_i && exp_q.size() > 0) void'(exp_q.pop_front());
		head = (exp_q.size() > 0) ? exp_q[0] : '0;
		exp_pending <= (exp_q.size() > 0);
		exp_last <= head[72];
		exp_mask <= head[71:64];
		exp_data <= head[63:0];
		for (int i = 0; i < 8; i++) exp_keep[i*8 +: 8] <= {8{head[64 + i]}};
		if (done_o) done_cnt <= done_cnt + 1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout in %s after %0d cycles, done_o never came", test_name, cycles);
			$display("Test failed");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(valid_o && wr_ready_i) |-> ((data_o & exp_keep) == exp_data))
	else begin
		$display("ERR %s: data expected %h actual %h", test_name, $sampled(exp_data),
			$sampled(data_o));
		assert_errs++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(valid_o && wr_ready_i) |-> (byte_valid_o == exp_mask && last_o == exp_last))
	else begin
		$display("ERR %s: mask/last expected %b/%b actual %b/%b", test_name,
			$sampled(exp_mask), $sampled(exp_last), $sampled(byte_valid_o), $sampled(last_o));
		assert_errs++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) valid_o |-> exp_pending)
	else begin
		$display("%s: valid_o raised with no word left in the block", test_name);
		assert_errs++;
	end

	// held word must not move under back-pressure
	assert property (@(posedge clk) disable iff (!rst_n) (valid_o && !wr_ready_i) |=>
		(valid_o && $stable(data_o) && $stable(byte_valid_o) && $stable(last_o)))
	else begin
		$display("%s: output word changed or dropped while wr_ready_i was low", test_name);
		assert_errs++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(valid_o && wr_ready_i && last_o) |=> done_o)
	else begin
		$display("%s: no done_o after the last word transferred", test_name);
		assert_errs++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		done_o |-> $past(valid_o && wr_ready_i && last_o))
	else begin
		$display("%s: done_o pulsed without a last word transfer before it", test_name);
		assert_errs++;
	end

	// fifo write pointer holds while input is refused
	assert property (@(posedge clk) disable iff (!rst_n)
		fifo_almost_full_o |=> $stable(snappy_decompressor_i.u_byte_fifo.wr_ptr_q))
	else begin
		$display("%s: byte pushed into the input FIFO while almost full", test_name);
		assert_errs++;
	end

	initial begin
		rst_n = 1'b0;
		start_i = 1'b0;
		decomp_len_i = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		add_literal(37);
		add_literal(60);
		add_literal(5);
		run_block("literal_only", 0, 0);

		add_literal(1);
		add_copy1(1, 11);                          // offset 1 overlaps its own output
		run_block("overlap_copy", 0, 0);

		add_literal(60);
		fill_random(2600, 1'b0);                   // longer than the 2 KiB window
		run_block("copy2_window", 0, 0);

		fill_random(400, 1'b1);
		run_block("backpressure", 40, 30);

		add_literal(20);
		add_copy2(20, 9);
		add_copy1(7, 4);                           // 33 bytes with one in the last word
		run_block("odd_length", 25, 0);

		$display("tests: %0d ok, %0d failing", passes, fails);
		if (fails == 0 && assert_errs + check_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: snappy_decompressor.f
src/snappy_pkg.sv
src/byte_fifo.sv
src/token_control.sv
src/history_ram.sv
src/output_packer.sv
src/snappy_decompressor.sv
sim/tb_snappy_decompressor.sv

// File: src/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
	input wire clk,
	input wire rst_n,
	input wire push_i,
	input wire [7:0] data_i,
	input wire pop_i,
	output logic [7:0] data_o,
	output logic empty_o,
	output logic almost_full_o
);

	logic [7:0] mem [snappy_pkg::FIFO_DEPTH];
	logic [snappy_pkg::FIFO_AW-1:0] wr_ptr_q;
	logic [snappy_pkg::FIFO_AW-1:0] rd_ptr_q;
	logic [snappy_pkg::FIFO_AW:0] count_q;
	logic [snappy_pkg::FIFO_AW:0] count_n;
	logic do_push;
	logic do_pop;

	// never overrun a full fifo, never pop an empty one
	assign do_push = push_i &&
		(count_q != (snappy_pkg::FIFO_AW + 1)'(snappy_pkg::FIFO_DEPTH));
	assign do_pop = pop_i && !empty_o;

	assign empty_o = (count_q == '0);
	assign data_o = mem[rd_ptr_q];               // head is always visible

	always_comb begin
		count_n = count_q;
		if (do_push && !do_pop) begin
			count_n = count_q + 1'b1;
		end else if (do_pop && !do_push) begin
			count_n = count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			almost_full_o <= 1'b0;
		end else begin
			if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_n;
			// level seen one cycle after the push or pop
			almost_full_o <= (count_n >=
				(snappy_pkg::FIFO_AW + 1)'(snappy_pkg::FIFO_ALMOST_FULL));
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr_q] <= data_i;
	end

endmodule

`default_nettype wire

// File: src/history_ram.sv
`timescale 1ns/1ps
`default_nettype none

module history_ram (
	input wire clk,
	input wire rst_n,
	input wire wr_en_i,
	input wire [7:0] wr_byte_i,
	input wire copy_rd_i,
	input wire [snappy_pkg::HIST_AW-1:0] copy_offset_i,
	output logic [7:0] out_byte_o,
	output logic out_strobe_o
);

	logic [7:0] mem [snappy_pkg::HIST_DEPTH];
	logic [snappy_pkg::HIST_AW-1:0] wr_ptr_q;   // next free slot, wraps
	logic [snappy_pkg::HIST_AW-1:0] rd_addr;
	logic [7:0] rd_data_q;
	logic copy_pend_q;                          // fetched byte lands this cycle

	assign rd_addr = wr_ptr_q - copy_offset_i;

	// copied byte has priority, control never overlaps the two
	assign out_byte_o = copy_pend_q ? rd_data_q : wr_byte_i;
	assign out_strobe_o = copy_pend_q || wr_en_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			copy_pend_q <= 1'b0;
		end else begin
			copy_pend_q <= copy_rd_i;
			if (out_strobe_o) wr_ptr_q <= wr_ptr_q + 1'b1;
		end
	end

	// window storage, read registered like a block ram
	always_ff @(posedge clk) begin
		if (out_strobe_o) mem[wr_ptr_q] <= out_byte_o;
		if (copy_rd_i) rd_data_q <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: src/output_packer.sv
`timescale 1ns/1ps
`default_nettype none

module output_packer (
	input wire clk,
	input wire rst_n,
	input wire [7:0] byte_i,
	input wire strobe_i,
	input wire flush_i,
	input wire ready_i,
	output logic [snappy_pkg::WORD_W-1:0] data_o,
	output logic [snappy_pkg::BYTES_PER_WORD-1:0] byte_valid_o,
	output logic valid_o,
	output logic last_o,
	output logic done_o,
	output logic stall_o
);

	logic [snappy_pkg::WORD_W-1:0] build_q;     // word being filled, byte 0 in bits 7..0
	logic [3:0] cnt_q;                          // bytes in build_q
	logic flush_pend_q;                         // flush seen, word not yet moved
	logic [snappy_pkg::BYTES_PER_WORD-1:0] mask;
	logic full;
	logic flush_now;
	logic out_free;
	logic move;

	assign full = (cnt_q == 4'(snappy_pkg::BYTES_PER_WORD));
	assign flush_now = flush_i || flush_pend_q;
	assign out_free = !valid_o || ready_i;
	assign move = out_free && (full || (flush_now && cnt_q != '0));

	// hold the parser while a full word cannot leave
	assign stall_o = full;

	always_comb begin
		for (int i = 0; i < snappy_pkg::BYTES_PER_WORD; i++) begin
			mask[i] = (cnt_q > i);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			build_q <= '0;
			cnt_q <= '0;
			flush_pend_q <= 1'b0;
			valid_o <= 1'b0;
			last_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			if (move) begin
				build_q <= '0;
				cnt_q <= '0;
			end else if (strobe_i) begin
				build_q[cnt_q[2:0]*8 +: 8] <= byte_i;
				cnt_q <= cnt_q + 4'd1;
			end

			if (move) begin
				flush_pend_q <= 1'b0;
			end else if (flush_i && cnt_q != '0) begin
				flush_pend_q <= 1'b1;
			end

			if (move) begin
				valid_o <= 1'b1;
				last_o <= flush_now;
			end else if (ready_i) begin
				valid_o <= 1'b0;
				last_o <= 1'b0;
			end

			// after the last word goes, or at once for an empty block
			done_o <= (valid_o && ready_i && last_o) || (flush_i && cnt_q == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (move) begin
			data_o <= build_q;
			byte_valid_o <= mask;
		end
	end

endmodule

`default_nettype wire

// File: src/snappy_decompressor.sv
`timescale 1ns/1ps
`default_nettype none

module snappy_decompressor (
	input wire clk,
	input wire rst_n,
	input wire [7:0] data_i,
	input wire valid_i,
	input wire start_i,
	input wire [snappy_pkg::LEN_W-1:0] decomp_len_i,
	input wire wr_ready_i,
	output logic fifo_almost_full_o,
	output logic [snappy_pkg::WORD_W-1:0] data_o,
	output logic [snappy_pkg::BYTES_PER_WORD-1:0] byte_valid_o,
	output logic valid_o,
	output logic last_o,
	output logic done_o
);

	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic [7:0] fifo_byte;
	logic stall;
	logic wr_en;
	logic [7:0] wr_byte;
	logic copy_rd;
	logic [snappy_pkg::HIST_AW-1:0] copy_offset;
	logic flush;
	logic [7:0] out_byte;
	logic out_strobe;

	// input accepted only below the almost-full level
	assign fifo_push = valid_i && !fifo_almost_full_o;

	byte_fifo u_byte_fifo (
		.clk(clk), .rst_n(rst_n), .push_i(fifo_push), .data_i(data_i), .pop_i(fifo_pop),
		.data_o(fifo_byte), .empty_o(fifo_empty), .almost_full_o(fifo_almost_full_o)
	);

	token_control u_token_control (
		.clk(clk), .rst_n(rst_n), .start_i(start_i), .decomp_len_i(decomp_len_i),
		.fifo_byte_i(fifo_byte), .fifo_empty_i(fifo_empty), .fifo_pop_o(fifo_pop),
		.stall_i(stall), .wr_en_o(wr_en), .wr_byte_o(wr_byte), .copy_rd_o(copy_rd),
		.copy_offset_o(copy_offset), .flush_o(flush)
	);

	history_ram u_history_ram (
		.clk(clk), .rst_n(rst_n), .wr_en_i(wr_en), .wr_byte_i(wr_byte),
		.copy_rd_i(copy_rd), .copy_offset_i(copy_offset),
		.out_byte_o(out_byte), .out_strobe_o(out_strobe)
	);

	output_packer u_output_packer (
		.clk(clk), .rst_n(rst_n), .byte_i(out_byte), .strobe_i(out_strobe),
		.flush_i(flush), .ready_i(wr_ready_i), .data_o(data_o),
		.byte_valid_o(byte_valid_o), .valid_o(valid_o), .last_o(last_o),
		.done_o(done_o), .stall_o(stall)
	);

endmodule

`default_nettype wire

// File: src/snappy_pkg.sv
`default_nettype none

package snappy_pkg;

	// history window
	localparam int HIST_AW = 11;                 // 2048 byte window
	localparam int HIST_DEPTH = 1 << HIST_AW;

	// input byte fifo
	localparam int FIFO_AW = 4;
	localparam int FIFO_DEPTH = 1 << FIFO_AW;
	localparam int FIFO_ALMOST_FULL = 12;        // refuse input at this fill

	// output words
	localparam int BYTES_PER_WORD = 8;
	localparam int WORD_W = 64;

	// decompressed length and remaining byte counter
	localparam int LEN_W = 20;

	// token_control states
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_TAG = 3'd1;
	localparam logic [2:0] ST_OFF_LO = 3'd2;
	localparam logic [2:0] ST_OFF_HI = 3'd3;
	localparam logic [2:0] ST_LIT = 3'd4;
	localparam logic [2:0] ST_COPY_RD = 3'd5;
	localparam logic [2:0] ST_COPY_WAIT = 3'd6;
	localparam logic [2:0] ST_FLUSH = 3'd7;

	// low two bits of every tag byte
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'b00,
		TAG_COPY_1 = 2'b01,
		TAG_COPY_2 = 2'b10,
		TAG_COPY_4 = 2'b11                       // not handled by the parser
	} tag_kind_e;

	// one tag byte, two ways to read it
	typedef union packed {
		struct packed {
			logic [5:0] len_m1;                  // literal and copy_2 length minus one
			tag_kind_e kind;
		} lit;
		struct packed {
			logic [2:0] off_hi;                  // offset bits 10..8
			logic [2:0] len_m4;                  // length minus four
			tag_kind_e kind;
		} cp1;
	} tag_u;

endpackage

`default_nettype wire

// File: src/token_control.sv
`timescale 1ns/1ps
`default_nettype none

module token_control (
	input wire clk,
	input wire rst_n,
	input wire start_i,
	input wire [snappy_pkg::LEN_W-1:0] decomp_len_i,
	input wire [7:0] fifo_byte_i,
	input wire fifo_empty_i,
	output logic fifo_pop_o,
	input wire stall_i,
	output logic wr_en_o,
	output logic [7:0] wr_byte_o,
	output logic copy_rd_o,
	output logic [snappy_pkg::HIST_AW-1:0] copy_offset_o,
	output logic flush_o
);

	logic [2:0] state_q;
	logic [2:0] state_n;
	logic [snappy_pkg::LEN_W-1:0] remain_q;     // bytes still owed to the block
	logic [6:0] run_q;                          // bytes left in this token, up to 64
	logic [snappy_pkg::HIST_AW-1:0] offset_q;
	snappy_pkg::tag_kind_e kind_q;
	snappy_pkg::tag_u tag;
	logic last_out;

	assign tag = fifo_byte_i;
	assign last_out = (remain_q == snappy_pkg::LEN_W'(1));

	// literal bytes go straight from the fifo head to the window
	assign wr_byte_o = fifo_byte_i;
	assign copy_offset_o = offset_q;

	always_comb begin
		state_n = state_q;
		fifo_pop_o = 1'b0;
		wr_en_o = 1'b0;
		copy_rd_o = 1'b0;
		flush_o = 1'b0;
		case (state_q)
			snappy_pkg::ST_IDLE: begin
				if (start_i) begin
					state_n = (decomp_len_i == '0) ? snappy_pkg::ST_FLUSH : snappy_pkg::ST_TAG;
				end
			end
			snappy_pkg::ST_TAG: begin
				if (!fifo_empty_i) begin
					fifo_pop_o = 1'b1;
					case (tag.lit.kind)
						snappy_pkg::TAG_LITERAL: state_n = snappy_pkg::ST_LIT;
						snappy_pkg::TAG_COPY_1: state_n = snappy_pkg::ST_OFF_LO;
						snappy_pkg::TAG_COPY_2: state_n = snappy_pkg::ST_OFF_LO;
						snappy_pkg::TAG_COPY_4: state_n = snappy_pkg::ST_FLUSH; // abandon block
					endcase
				end
			end
			snappy_pkg::ST_OFF_LO: begin
				if (!fifo_empty_i) begin
					fifo_pop_o = 1'b1;
					// copy_1 has only one extra byte
					if (kind_q == snappy_pkg::TAG_COPY_1) begin
						state_n = snappy_pkg::ST_COPY_RD;
					end else begin
						state_n = snappy_pkg::ST_OFF_HI;
					end
				end
			end
			snappy_pkg::ST_OFF_HI: begin
				if (!fifo_empty_i) begin
					fifo_pop_o = 1'b1;
					state_n = snappy_pkg::ST_COPY_RD;
				end
			end
			snappy_pkg::ST_LIT: begin
				if (!fifo_empty_i && !stall_i) begin
					fifo_pop_o = 1'b1;
					wr_en_o = 1'b1;
					if (last_out) begin
						state_n = snappy_pkg::ST_FLUSH;
					end else if (run_q == 7'd1) begin
						state_n = snappy_pkg::ST_TAG;
					end
				end
			end
			snappy_pkg::ST_COPY_RD: begin
				if (!stall_i) begin
					copy_rd_o = 1'b1;
					state_n = snappy_pkg::ST_COPY_WAIT;
				end
			end
			snappy_pkg::ST_COPY_WAIT: begin
				// window writes the fetched byte this cycle
				if (remain_q == '0) begin
					state_n = snappy_pkg::ST_FLUSH;
				end else if (run_q == '0) begin
					state_n = snappy_pkg::ST_TAG;
				end else begin
					state_n = snappy_pkg::ST_COPY_RD;
				end
			end
			snappy_pkg::ST_FLUSH: begin
				flush_o = 1'b1;
				state_n = snappy_pkg::ST_IDLE;
			end
			default: state_n = snappy_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= snappy_pkg::ST_IDLE;
			remain_q <= '0;
			run_q <= '0;
		end else begin
			state_q <= state_n;
			if (state_q == snappy_pkg::ST_IDLE && start_i) remain_q <= decomp_len_i;
			if (state_q == snappy_pkg::ST_TAG && fifo_pop_o) begin
				if (tag.lit.kind == snappy_pkg::TAG_COPY_1) begin
					run_q <= 7'(tag.cp1.len_m4) + 7'd4;
				end else begin
					run_q <= 7'(tag.lit.len_m1) + 7'd1; // literal and copy_2
				end
			end
			if (wr_en_o || copy_rd_o) begin
				run_q <= run_q - 7'd1;
				remain_q <= remain_q - 1'b1;
			end
		end
	end

	// tag kind and copy offset
	always_ff @(posedge clk) begin
		if (state_q == snappy_pkg::ST_TAG && fifo_pop_o) begin
			kind_q <= tag.lit.kind;
			offset_q[snappy_pkg::HIST_AW-1:8] <= tag.cp1.off_hi;
		end
		if (state_q == snappy_pkg::ST_OFF_LO && fifo_pop_o) offset_q[7:0] <= fifo_byte_i;
		if (state_q == snappy_pkg::ST_OFF_HI && fifo_pop_o) begin
			offset_q[snappy_pkg::HIST_AW-1:8] <= fifo_byte_i[snappy_pkg::HIST_AW-9:0];
		end
	end

endmodule

`default_nettype wire
